/* filelist.f */
+incdir+verilog
verilog/ecc_pkg.sv
verilog/ecc_decode_if.sv
verilog/secded_encoder.sv
verilog/syndrome_locator.sv
verilog/ecc_ctrl.sv
verilog/ecc_output_stage.sv
verilog/ecc_86_top.sv
verification/ecc_86_checker.sv
verification/ecc_86_tb.sv

/* Bender.yml */
package:
  name: ecc_86

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/ecc_pkg.sv
      - verilog/ecc_decode_if.sv
      - verilog/secded_encoder.sv
      - verilog/syndrome_locator.sv
      - verilog/ecc_ctrl.sv
      - verilog/ecc_output_stage.sv
      - verilog/ecc_86_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verification/ecc_86_checker.sv
      - verification/ecc_86_tb.sv

/* verification/ecc_86_tb.sv */
`timescale 1ns/1ps
`include "ecc_cfg.svh"

module ecc_86_tb;

    localparam int NUM_VECTORS    = 2000;
    localparam int TIMEOUT_CYCLES = NUM_VECTORS + 20;
    localparam int CODE_W         = `ECC_DATA_W + `ECC_CHECK_W;

    localparam int KIND_CLEAN  = 0;
    localparam int KIND_DATA   = 1;
    localparam int KIND_CHECK  = 2;
    localparam int KIND_DOUBLE = 3;
    localparam int KIND_BYPASS = 4;

    typedef struct packed {
        logic [`ECC_DATA_W-1:0]  data;
        logic [`ECC_CHECK_W-1:0] parity;
        logic                    sbit;
        logic                    dbit;
    } expect_t;

    logic                    clk;
    logic                    arst_n;
    logic [`ECC_DATA_W-1:0]  data_in;
    logic [`ECC_CHECK_W-1:0] parity_in;
    logic                    bypass;
    logic [`ECC_DATA_W-1:0]  data_out;
    logic [`ECC_CHECK_W-1:0] parity_out;
    logic                    sbit_err;
    logic                    dbit_err;

    logic [31:0]             lfsr_state = 32'd86273;
    logic [`ECC_CHECK_W-1:0] col_table [`ECC_DATA_W];
    expect_t                 exp_q [$];
    int                      err_count = 0;
    int                      cycle_count = 0;
    int                      kind_count [5];

    ecc_86_top DUT (
        .clk        (clk),
        .arst_n     (arst_n),
        .data_in    (data_in),
        .parity_in  (parity_in),
        .bypass     (bypass),
        .data_out   (data_out),
        .parity_out (parity_out),
        .sbit_err   (sbit_err),
        .dbit_err   (dbit_err)
    );

    bind ecc_86_top ecc_86_checker u_checker (
        .clk      (clk),
        .arst_n   (arst_n),
        .bypass   (bypass),
        .data_in  (data_in),
        .data_out (data_out),
        .sbit_err (sbit_err),
        .dbit_err (dbit_err)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d clock cycles.", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    // Galois form, taps for x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    function automatic int unsigned rand_below(input int unsigned limit, input int width);
        int unsigned v;
        v = rand_bits(width);
        while (v >= limit) begin
            v = rand_bits(width);
        end
        return v;
    endfunction

    function automatic logic [`ECC_DATA_W-1:0] rand_word();
        logic [95:0] w;
        w[31:0]  = rand_bits(32);
        w[63:32] = rand_bits(32);
        w[95:64] = rand_bits(`ECC_DATA_W - 64);
        return w[`ECC_DATA_W-1:0];
    endfunction

    // Walk Hamming positions from 3 and count only those that are not powers of two.
    function automatic logic [`ECC_CHECK_W-1:0] model_column(input int idx);
        int         pos;
        int         n;
        logic [6:0] p;
        pos = 2;
        n = -1;
        while (n < idx) begin
            pos++;
            if ((pos & (pos - 1)) != 0) begin
                n++;
            end
        end
        p = pos[6:0];
        return {~^p, p};
    endfunction

    function automatic logic [`ECC_CHECK_W-1:0] model_check(input logic [`ECC_DATA_W-1:0] d);
        logic [`ECC_CHECK_W-1:0] c;
        c = '0;
        for (int i = 0; i < `ECC_DATA_W; i++) begin
            if (d[i]) begin
                c = c ^ col_table[i];
            end
        end
        return c;
    endfunction

    task automatic compare(input string name, input logic [127:0] exp_val,
                           input logic [127:0] act_val);
        if (act_val !== exp_val) begin
            err_count++;
            $display("[FAIL] time=%0t signal=%s expected=%h actual=%h",
                     $time, name, exp_val, act_val);
            $display("TEST FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_reset_zero();
        compare("data_out", '0, data_out);
        compare("parity_out", '0, parity_out);
        compare("sbit_err", '0, sbit_err);
        compare("dbit_err", '0, dbit_err);
    endtask

    task automatic apply_vector();
        logic [`ECC_DATA_W-1:0] word;
        logic [CODE_W-1:0]      cw;
        logic                   drive_bypass;
        expect_t                e;
        int unsigned            kind;
        int unsigned            p1;
        int unsigned            p2;
        word = rand_word();
        cw = {model_check(word), word};
        drive_bypass = 1'b0;
        e.data = word;
        e.sbit = 1'b0;
        e.dbit = 1'b0;
        if (rand_bits(3) == 0) begin
            kind = KIND_BYPASS;
        end else begin
            kind = rand_bits(2);
        end
        case (kind)
            KIND_DATA: begin
                p1 = rand_below(`ECC_DATA_W, 7);
                cw[p1] = ~cw[p1];
                e.sbit = 1'b1;
            end
            KIND_CHECK: begin
                p1 = `ECC_DATA_W + rand_below(`ECC_CHECK_W, 3);
                cw[p1] = ~cw[p1];
                e.sbit = 1'b1;
            end
            KIND_DOUBLE: begin
                p1 = rand_below(CODE_W, 7);
                p2 = p1;
                while (p2 == p1) begin
                    p2 = rand_below(CODE_W, 7);
                end
                cw[p1] = ~cw[p1];
                cw[p2] = ~cw[p2];
                // Nothing is corrected, so the word comes out as it went in.
                e.data = cw[`ECC_DATA_W-1:0];
                e.dbit = 1'b1;
            end
            KIND_BYPASS: begin
                cw[CODE_W-1:`ECC_DATA_W] = cw[CODE_W-1:`ECC_DATA_W] ^ rand_bits(8);
                drive_bypass = 1'b1;
                e.data = cw[`ECC_DATA_W-1:0];
            end
            default: begin
            end
        endcase
        e.parity = model_check(cw[`ECC_DATA_W-1:0]);
        kind_count[kind]++;
        data_in   = cw[`ECC_DATA_W-1:0];
        parity_in = cw[CODE_W-1:`ECC_DATA_W];
        bypass    = drive_bypass;
        exp_q.push_back(e);
    endtask

    task automatic check_outputs();
        expect_t e;
        if (exp_q.size() == 0) begin
            $display("No expected result was waiting when the outputs were sampled.");
            $display("TEST FAILED");
            $fatal(1, "model queue underflow");
        end
        e = exp_q.pop_front();
        compare("data_out", e.data, data_out);
        compare("parity_out", e.parity, parity_out);
        compare("sbit_err", e.sbit, sbit_err);
        compare("dbit_err", e.dbit, dbit_err);
    endtask

    initial begin
        for (int i = 0; i < `ECC_DATA_W; i++) begin
            col_table[i] = model_column(i);
        end
        for (int k = 0; k < 5; k++) begin
            kind_count[k] = 0;
        end
        arst_n    = 1'b1;
        data_in   = rand_word();
        parity_in = rand_bits(8);
        bypass    = 1'b0;
        #1 arst_n = 1'b0;

        // Inputs carry a random word during reset, yet every output stays at zero.
        repeat (3) begin
            @(posedge clk);
            #1;
            check_reset_zero();
        end
        arst_n = 1'b1;

        // Released registers hold zero until the next edge samples an input.
        @(negedge clk);
        check_reset_zero();
        @(posedge clk);
        #1;

        for (int n = 0; n < NUM_VECTORS; n++) begin
            apply_vector();
            @(posedge clk);
            #1;
            check_outputs();
        end

        // One more edge lets the bound assertions finish on the last vector.
        @(posedge clk);
        #1;

        $display("Vectors: clean %0d, data %0d, check %0d, double %0d, bypass %0d",
                 kind_count[KIND_CLEAN], kind_count[KIND_DATA], kind_count[KIND_CHECK],
                 kind_count[KIND_DOUBLE], kind_count[KIND_BYPASS]);
        if (err_count == 0 && DUT.u_checker.fail_count == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            $display("TEST FAILED");
            $fatal(1, "%0d checks and %0d assertions failed",
                   err_count, DUT.u_checker.fail_count);
        end
    end

endmodule

/* verification/ecc_86_checker.sv */
`timescale 1ns/1ps
`include "ecc_cfg.svh"

module ecc_86_checker (
    input logic                   clk,
    input logic                   arst_n,
    input logic                   bypass,
    input logic [`ECC_DATA_W-1:0] data_in,
    input logic [`ECC_DATA_W-1:0] data_out,
    input logic                   sbit_err,
    input logic                   dbit_err
);

    // Number of assertion failures seen so far.
    int fail_count = 0;

    // A word is either single or double, never both.
    property p_flags_exclusive;
        @(posedge clk) disable iff (!arst_n) !(sbit_err && dbit_err);
    endproperty

    property p_bypass_quiet;
        @(posedge clk) disable iff (!arst_n) bypass |=> (!sbit_err && !dbit_err);
    endproperty

    property p_reset_flags;
        @(posedge clk) !arst_n |-> (!sbit_err && !dbit_err);
    endproperty

    // Under bypass the registered word is the raw input from the cycle before.
    property p_bypass_data;
        @(posedge clk) disable iff (!arst_n) bypass |=> (data_out == $past(data_in));
    endproperty

    a_flags_exclusive: assert property (p_flags_exclusive)
        else begin
            fail_count++;
            $error("sbit_err and dbit_err are high in the same cycle");
        end

    a_bypass_quiet: assert property (p_bypass_quiet)
        else begin
            fail_count++;
            $error("an error flag is set after a bypass cycle");
        end

    a_reset_flags: assert property (p_reset_flags)
        else begin
            fail_count++;
            $error("an error flag is set while arst_n is low");
        end

    a_bypass_data: assert property (p_bypass_data)
        else begin
            fail_count++;
            $error("data_out differs from the bypassed data_in");
        end

endmodule

/* verilog/ecc_86_top.sv */
`timescale 1ns/1ps
`include "ecc_cfg.svh"

module ecc_86_top (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic [`ECC_DATA_W-1:0]  data_in,
    input  logic [`ECC_CHECK_W-1:0] parity_in,
    input  logic                    bypass,
    output logic [`ECC_DATA_W-1:0]  data_out,
    output logic [`ECC_CHECK_W-1:0] parity_out,
    output logic                    sbit_err,
    output logic                    dbit_err
);

    // Check bits recomputed from the incoming data word.
    logic [`ECC_CHECK_W-1:0] check;
    logic                    correct_en;

    ecc_decode_if dec_if ();

    secded_encoder u_encoder (
        .data  (data_in),
        .check (check)
    );

    syndrome_locator u_locator (
        .parity (parity_in),
        .check  (check),
        .dec    (dec_if.locator)
    );

    ecc_ctrl u_ctrl (
        .clk        (clk),
        .arst_n     (arst_n),
        .bypass     (bypass),
        .dec        (dec_if.ctrl),
        .correct_en (correct_en),
        .sbit_err   (sbit_err),
        .dbit_err   (dbit_err)
    );

    // Registers line up with the flag registers in the control block.
    ecc_output_stage u_output_stage (
        .clk        (clk),
        .arst_n     (arst_n),
        .data       (data_in),
        .check      (check),
        .correct_en (correct_en),
        .dec        (dec_if.stage),
        .data_out   (data_out),
        .parity_out (parity_out)
    );

endmodule

/* verilog/ecc_output_stage.sv */
`timescale 1ns/1ps
`include "ecc_cfg.svh"

module ecc_output_stage (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic [`ECC_DATA_W-1:0]  data,
    input  logic [`ECC_CHECK_W-1:0] check,
    input  logic                    correct_en,
    ecc_decode_if.stage             dec,
    output logic [`ECC_DATA_W-1:0]  data_out,
    output logic [`ECC_CHECK_W-1:0] parity_out
);

    logic [`ECC_DATA_W-1:0] data_fix;

    // Only a data-bit hit flips anything. A check-bit error passes the data as is.
    always_comb begin
        data_fix = data;
        if (correct_en && dec.data_hit) begin
            data_fix[dec.bit_index] = ~data[dec.bit_index];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            data_out   <= '0;
            parity_out <= '0;
        end else begin
            data_out   <= data_fix;
            parity_out <= check;
        end
    end

endmodule

/* verilog/ecc_ctrl.sv */
`timescale 1ns/1ps

module ecc_ctrl (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       bypass,
    ecc_decode_if.ctrl dec,
    output logic       correct_en,
    output logic       sbit_err,
    output logic       dbit_err
);

    ecc_pkg::err_class_e err_class;

    // Bypass hides every error, whatever the syndrome says.
    always_comb begin
        if (bypass) begin
            err_class = ecc_pkg::ERR_NONE;
        end else if (dec.zero) begin
            err_class = ecc_pkg::ERR_NONE;
        end else if (dec.data_hit || dec.check_hit) begin
            err_class = ecc_pkg::ERR_SINGLE;
        end else begin
            err_class = ecc_pkg::ERR_DOUBLE;
        end
    end

    assign correct_en = err_class == ecc_pkg::ERR_SINGLE;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sbit_err <= 1'b0;
            dbit_err <= 1'b0;
        end else begin
            sbit_err <= err_class == ecc_pkg::ERR_SINGLE;
            dbit_err <= err_class == ecc_pkg::ERR_DOUBLE;
        end
    end

endmodule

/* verilog/syndrome_locator.sv */
`timescale 1ns/1ps
`include "ecc_cfg.svh"

module syndrome_locator (
    input  logic [`ECC_CHECK_W-1:0] parity,
    input  logic [`ECC_CHECK_W-1:0] check,
    ecc_decode_if.locator           dec
);

    localparam logic [`ECC_CHECK_W-1:0] last_col = ecc_pkg::data_column(`ECC_DATA_W - 1);
    localparam logic [`ECC_POS_W-1:0]   first_pos = 3;

    logic [`ECC_POS_W-1:0] pos;
    logic                  pos_pow2;
    logic                  pos_valid;
    logic [`ECC_POS_W-1:0] pow2_cnt;

    assign dec.syndrome = parity ^ check;

    assign pos = dec.syndrome.f.pos;

    // Zero also counts as a power of two here, so it never maps to data.
    assign pos_pow2 = (pos & (pos - 1'b1)) == '0;

    assign pos_valid = !pos_pow2 && (pos >= first_pos) &&
                       (pos <= last_col[`ECC_POS_W-1:0]);

    // A data column has odd weight, so the top bit must match the parity of pos.
    assign dec.data_hit = pos_valid && (dec.syndrome.f.weight == ~^pos);

    always_comb begin
        pow2_cnt = '0;
        for (int k = 0; k < `ECC_POS_W; k++) begin
            if (pos >= (1 << k)) begin
                pow2_cnt = pow2_cnt + 1'b1;
            end
        end
    end

    // Positions start at one and skip every power of two below them.
    assign dec.bit_index = pos - 1'b1 - pow2_cnt;

    assign dec.zero = dec.syndrome.raw == '0;

    // A flipped check bit leaves a one-hot syndrome.
    assign dec.check_hit = !dec.zero &&
                           ((dec.syndrome.raw & (dec.syndrome.raw - 1'b1)) == '0);

endmodule

/* verilog/secded_encoder.sv */
`timescale 1ns/1ps
`include "ecc_cfg.svh"

module secded_encoder (
    input  logic [`ECC_DATA_W-1:0]  data,
    output logic [`ECC_CHECK_W-1:0] check
);

    // Collects the data bits whose column has check bit k set.
    function automatic logic [`ECC_DATA_W-1:0] build_row(input int unsigned k);
        logic [`ECC_DATA_W-1:0]  row;
        logic [`ECC_CHECK_W-1:0] col;
        row = '0;
        for (int i = 0; i < `ECC_DATA_W; i++) begin
            col = ecc_pkg::data_column(i);
            row[i] = col[k];
        end
        return row;
    endfunction

    genvar k;

    generate
        for (k = 0; k < `ECC_CHECK_W; k++) begin : g_check
            localparam logic [`ECC_DATA_W-1:0] row = build_row(k);

            // Each check bit is the parity of the data bits on its row.
            assign check[k] = ^(data & row);
        end
    endgenerate

endmodule

/* verilog/ecc_decode_if.sv */
`timescale 1ns/1ps
`include "ecc_cfg.svh"

interface ecc_decode_if;

    ecc_pkg::syndrome_u    syndrome;
    logic                  zero;
    logic                  data_hit;
    logic                  check_hit;
    logic [`ECC_POS_W-1:0] bit_index;

    modport locator (
        output syndrome,
        output zero,
        output data_hit,
        output check_hit,
        output bit_index
    );

    modport ctrl (input zero, input data_hit, input check_hit);

    modport stage (input data_hit, input bit_index);

endinterface

/* verilog/ecc_pkg.sv */
`include "ecc_cfg.svh"

package ecc_pkg;

    // The same syndrome word is read as a whole and as weight plus position.
    typedef union packed {
        logic [`ECC_CHECK_W-1:0] raw;
        struct packed {
            logic                  weight;
            logic [`ECC_POS_W-1:0] pos;
        } f;
    } syndrome_u;

    typedef enum logic [1:0] {
        ERR_NONE   = 2'd0,
        ERR_SINGLE = 2'd1,
        ERR_DOUBLE = 2'd2
    } err_class_e;

    // Data bit idx sits at the idx-th position from 3 that is not a power of two.
    // The top bit makes the weight of the column odd.
    function automatic logic [`ECC_CHECK_W-1:0] data_column(input int unsigned idx);
        int unsigned           pos;
        logic [`ECC_POS_W-1:0] p;
        pos = idx + 3;
        for (int k = 2; k < `ECC_POS_W; k++) begin
            if (pos >= (1 << k)) begin
                pos++;
            end
        end
        p = pos[`ECC_POS_W-1:0];
        return {~^p, p};
    endfunction

endpackage

/* verilog/ecc_cfg.svh */
`ifndef ECC_CFG_SVH
`define ECC_CFG_SVH

// Width of the protected data word.
`define ECC_DATA_W 86

// Seven Hamming check bits plus one overall weight bit.
`define ECC_CHECK_W 8

// Width of a Hamming position.
// It is also the low part of every check column.
`define ECC_POS_W 7

`endif
